/* vlog.f */
rtl/sifhTypesPkg.sv
rtl/sifhCtrlPkg.sv
rtl/histRam.sv
rtl/histogramBuilder.sv
rtl/peakFinder.sv
rtl/sifhSequencer.sv
rtl/sifhTop.sv
test/sifhTb.sv

/* Makefile */
# Verilator build of the histogram peak finder testbench

SRCS = $(wildcard rtl/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

obj_dir/sifhSim: vlog.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module sifhTb -Mdir obj_dir -o sifhSim

run: obj_dir/sifhSim
	./obj_dir/sifhSim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/sifhTb.sv */
`timescale 1ns/1ps

module sifhTb;

    import sifhTypesPkg::*;

    localparam int mainShots = 64;
    localparam int satShots  = 300;  // above the 8 bit count limit
    localparam int sigWanted = 0;
    localparam int sigAck    = 1;
    localparam int sigResReq = 2;

    logic    clk;
    logic    res;
    logic    tdcReq;
    tdcCode  tdc;
    logic    resAck;
    logic    useSat;    // stimulus goes to the saturation DUT

    // outputs of the 64 shot DUT
    logic    mainAck;
    logic    mainWanted;
    logic    mainResReq;
    peakCode mainPeak;
    binCount mainCount;
    // outputs of the 300 shot DUT
    logic    satAck;
    logic    satWanted;
    logic    satResReq;
    peakCode satPeak;
    binCount satCount;
    // whichever DUT is selected
    logic    ack;
    logic    wanted;
    logic    resReqSeen;
    peakCode peak;
    binCount count;

    tdcCode      frame [satShots];  // one frame resent for each pass
    logic [31:0] lfsr;
    int          testErrs;
    int          testsRun;
    int          testsFailed;
    bit          timedOut;

    sifhTop #(.SHOTS(mainShots)) dut_i (
        .clk(clk), .res(res), .tdcReq(tdcReq && !useSat), .tdc(tdc), .tdcAck(mainAck),
        .dataWanted(mainWanted), .resReq(mainResReq), .resAck(resAck && !useSat),
        .peak(mainPeak), .peakCount(mainCount)
    );

    sifhTop #(.SHOTS(satShots)) satDut_i (
        .clk(clk), .res(res), .tdcReq(tdcReq && useSat), .tdc(tdc), .tdcAck(satAck),
        .dataWanted(satWanted), .resReq(satResReq), .resAck(resAck && useSat),
        .peak(satPeak), .peakCount(satCount)
    );

    assign ack        = useSat ? satAck : mainAck;
    assign wanted     = useSat ? satWanted : mainWanted;
    assign resReqSeen = useSat ? satResReq : mainResReq;
    assign peak       = useSat ? satPeak : mainPeak;
    assign count      = useSat ? satCount : mainCount;

    always #50 clk = ~clk;  // 100 ns period

    // Galois LFSR with x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic sigValue(input int sig);
        case (sig)
            sigWanted: return wanted;
            sigAck:    return ack;
            default:   return resReqSeen;
        endcase
    endfunction

    // polls on falling edges and gives up after limit cycles
    task automatic waitLevel(input int sig, input logic level, input int limit,
                             input string what);
        int n;
        n = 0;
        if (timedOut) return;
        while (sigValue(sig) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (sigValue(sig) !== level) begin
            $display("timeout after %0d cycles waiting for %s", limit, what);
            timedOut = 1'b1;
        end
    endtask

    // reference histograms for 12 bit stamps with 5 bit bins and 8 bit counts
    task automatic modelResult(input int n, output peakCode expPeak, output binCount expCount);
        int hist [32];
        int best;
        int win;
        int fineBin;
        int b;
        for (int i = 0; i < 32; i++) hist[i] = 0;
        for (int i = 0; i < n; i++) begin
            b = int'(frame[i][11:7]);
            if (hist[b] < 255) hist[b]++;  // count holds at all ones
        end
        best = 0;
        win  = 0;
        for (int i = 0; i < 32; i++) begin
            if (hist[i] > best) begin  // first maximum wins a tie
                best = hist[i];
                win  = i;
            end
        end
        // second pass only counts stamps inside the coarse window
        for (int i = 0; i < 32; i++) hist[i] = 0;
        for (int i = 0; i < n; i++) begin
            if (int'(frame[i][11:7]) == win) begin
                b = int'(frame[i][6:2]);
                if (hist[b] < 255) hist[b]++;
            end
        end
        best    = 0;
        fineBin = 0;
        for (int i = 0; i < 32; i++) begin
            if (hist[i] > best) begin
                best    = hist[i];
                fineBin = i;
            end
        end
        expPeak  = {5'(win), 5'(fineBin)};
        expCount = 8'(best);
    endtask

    // one pass of the frame over the four-phase handshake
    task automatic sendPass(input int shots);
        waitLevel(sigWanted, 1'b1, 2000, "dataWanted to rise");
        for (int i = 0; i < shots; i++) begin
            if (timedOut) return;
            tdc    = frame[i];
            tdcReq = 1'b1;
            waitLevel(sigAck, 1'b1, 20, "tdcAck to rise");
            tdcReq = 1'b0;
            waitLevel(sigAck, 1'b0, 20, "tdcAck to fall");
        end
        waitLevel(sigWanted, 1'b0, 20, "dataWanted to fall after the pass");
    endtask

    // both passes and then the result handshake with ackDelay cycles of hold
    task automatic runFrame(input string name, input int shots, input int ackDelay);
        peakCode expPeak;
        binCount expCount;
        modelResult(shots, expPeak, expCount);
        sendPass(shots);
        sendPass(shots);
        waitLevel(sigResReq, 1'b1, 500, "resReq to rise");
        if (timedOut) return;
        if (peak !== expPeak) begin
            $display("[FAIL] %s: peak expected %h, actual %h", name, expPeak, peak);
            testErrs++;
        end
        if (count !== expCount) begin
            $display("[FAIL] %s: peakCount expected %0d, actual %0d", name, expCount, count);
            testErrs++;
        end
        repeat (ackDelay) begin
            @(negedge clk);
            if (peak !== expPeak || count !== expCount) begin
                $display("[FAIL] %s: held result expected %h/%0d, actual %h/%0d",
                         name, expPeak, expCount, peak, count);
                testErrs++;
            end
            if (resReqSeen !== 1'b1) begin
                $display("%s: resReq dropped before resAck was given", name);
                testErrs++;
            end
        end
        resAck = 1'b1;
        waitLevel(sigResReq, 1'b0, 20, "resReq to fall");
        @(negedge clk);
        resAck = 1'b0;
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrs == 0 && !timedOut) begin
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, testErrs);
        end
    endtask

    task automatic testResetState();
        testErrs = 0;
        if (wanted !== 1'b0) begin
            $display("[FAIL] reset: dataWanted expected 0, actual %b", wanted);
            testErrs++;
        end
        if (ack !== 1'b0) begin
            $display("[FAIL] reset: tdcAck expected 0, actual %b", ack);
            testErrs++;
        end
        if (resReqSeen !== 1'b0) begin
            $display("[FAIL] reset: resReq expected 0, actual %b", resReqSeen);
            testErrs++;
        end
        waitLevel(sigWanted, 1'b1, 100, "dataWanted to rise after reset");  // no stimulus
        finishTest("reset");
    endtask

    task automatic testConstant();
        testErrs = 0;
        for (int i = 0; i < mainShots; i++) frame[i] = 12'h9c6;
        runFrame("constant", mainShots, 0);
        if (!timedOut && peak !== 10'h271) begin  // top ten bits of 9c6
            $display("[FAIL] constant: peak expected %h, actual %h", 10'h271, peak);
            testErrs++;
        end
        if (!timedOut && count !== 8'(mainShots)) begin
            $display("[FAIL] constant: peakCount expected %0d, actual %0d", mainShots, count);
            testErrs++;
        end
        finishTest("constant");
    endtask

    task automatic testNoiseCluster();
        logic [4:0] c;
        testErrs = 0;
        for (int i = 0; i < mainShots; i++) begin
            if (i % 16 < 9) begin
                // cluster in coarse bin 7 over fine bins 12 and 13
                frame[i] = {5'd7, 5'd12 + 5'(randBits(1)), 2'(randBits(2))};
            end else if (i % 2 == 0) begin
                c = 5'(randBits(5));
                if (c == 5'd7) c = 5'd8;  // same fine bits but outside the window
                frame[i] = {c, 5'd12, 2'(randBits(2))};
            end else begin
                frame[i] = 12'(randBits(12));
            end
        end
        runFrame("noise", mainShots, 0);
        if (!timedOut && peak[9:5] !== 5'd7) begin
            $display("[FAIL] noise: window expected %h, actual %h", 5'd7, peak[9:5]);
            testErrs++;
        end
        finishTest("noise");
    endtask

    task automatic testSaturation();
        testErrs = 0;
        useSat   = 1'b1;
        for (int i = 0; i < satShots; i++) begin
            if (i % 15 == 14) frame[i] = 12'(randBits(12));
            else frame[i] = 12'h6d5;
        end
        runFrame("saturation", satShots, 0);
        if (!timedOut && count !== 8'hff) begin
            $display("[FAIL] saturation: peakCount expected %h, actual %h", 8'hff, count);
            testErrs++;
        end
        useSat = 1'b0;
        finishTest("saturation");
    endtask

    task automatic testTie();
        testErrs = 0;
        // coarse bins 19 and 3 with equal counts and the upper bin sent first
        for (int i = 0; i < mainShots; i++) begin
            frame[i] = (i % 2 == 0) ? 12'h9a4 : 12'h1a8;
        end
        runFrame("tie", mainShots, 0);
        if (!timedOut && peak[9:5] !== 5'd3) begin
            $display("[FAIL] tie: window expected %h, actual %h", 5'd3, peak[9:5]);
            testErrs++;
        end
        finishTest("tie");
    endtask

    task automatic testBackPressure();
        testErrs = 0;
        for (int i = 0; i < mainShots; i++) frame[i] = 12'h5a7;
        runFrame("back-pressure", mainShots, 40);
        // fewer hits on the same bin so stale counts would show up here
        for (int i = 0; i < mainShots; i++) begin
            frame[i] = (i % 8 < 5) ? 12'h5a7 : 12'h123;
        end
        runFrame("back-pressure rerun", mainShots, 0);
        finishTest("back-pressure");
    endtask

    initial begin
        clk         = 1'b0;
        res         = 1'b0;
        tdcReq      = 1'b0;
        tdc         = '0;
        resAck      = 1'b0;
        useSat      = 1'b0;
        lfsr        = 32'hfdc9_0a92;
        testErrs    = 0;
        testsRun    = 0;
        testsFailed = 0;
        timedOut    = 1'b0;
        repeat (2) @(negedge clk);
        res = 1'b1;
        testResetState();
        if (!timedOut) testConstant();
        if (!timedOut) testNoiseCluster();
        if (!timedOut) testSaturation();
        if (!timedOut) testTie();
        if (!timedOut) testBackPressure();
        $display("tests run %0d, passed %0d, failed %0d",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0 && !timedOut) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* rtl/sifhTop.sv */
`timescale 1ns/1ps

module sifhTop #(
    parameter int NP    = $bits(sifhTypesPkg::tdcCode),
    parameter int NB    = $bits(sifhTypesPkg::binAddr),
    parameter int CW    = $bits(sifhTypesPkg::binCount),
    parameter int SHOTS = 64  // timestamps per frame
) (
    input  logic           clk,
    input  logic           res,
    input  logic           tdcReq,
    input  logic [NP-1:0]  tdc,
    output logic           tdcAck,
    output logic           dataWanted,
    output logic           resReq,
    input  logic           resAck,
    output logic [2*NB-1:0] peak,       // coarse bin : fine bin
    output logic [CW-1:0]  peakCount
);

    import sifhCtrlPkg::*;

    passKind       pass;
    logic [NB-1:0] window;
    logic          buildGo, buildDone;
    logic          scanGo, scanDone;
    logic [NB-1:0] maxBin;
    logic [CW-1:0] maxCount;
    // builder side of the RAM
    logic [NB-1:0] buildRaddr, buildWaddr;
    logic [CW-1:0] buildWdata;
    logic          buildWe;
    // peak finder read address
    logic [NB-1:0] scanRaddr;
    // RAM ports after the muxes
    logic          ramWe, ramSel;
    logic [NB-1:0] ramWaddr, ramRaddr;
    logic [CW-1:0] ramWdata, ramRdata;

    assign ramRaddr = ramSel ? scanRaddr : buildRaddr;  // read port mux

    sifhSequencer #(.NB(NB), .CW(CW)) sequencer_i (
        .clk(clk), .res(res), .dataWanted(dataWanted),
        .buildGo(buildGo), .pass(pass), .window(window), .buildDone(buildDone),
        .scanGo(scanGo), .scanDone(scanDone), .maxBin(maxBin), .maxCount(maxCount),
        .builderWe(buildWe), .builderWaddr(buildWaddr), .builderWdata(buildWdata),
        .ramWe(ramWe), .ramWaddr(ramWaddr), .ramWdata(ramWdata), .ramSel(ramSel),
        .resReq(resReq), .resAck(resAck), .peak(peak), .peakCount(peakCount)
    );

    histogramBuilder #(.NP(NP), .NB(NB), .CW(CW), .SHOTS(SHOTS)) builder_i (
        .clk(clk), .res(res), .buildGo(buildGo), .pass(pass), .window(window),
        .tdcReq(tdcReq), .tdc(tdc), .tdcAck(tdcAck),
        .ramRaddr(buildRaddr), .ramRdata(ramRdata),
        .ramWe(buildWe), .ramWaddr(buildWaddr), .ramWdata(buildWdata),
        .buildDone(buildDone)
    );

    peakFinder #(.NB(NB), .CW(CW)) finder_i (
        .clk(clk), .res(res), .scanGo(scanGo),
        .ramRaddr(scanRaddr), .ramRdata(ramRdata),
        .maxBin(maxBin), .maxCount(maxCount), .scanDone(scanDone)
    );

    histRam #(.NB(NB), .CW(CW)) ram_i (
        .clk(clk), .we(ramWe), .waddr(ramWaddr), .wdata(ramWdata),
        .raddr(ramRaddr), .rdata(ramRdata)
    );

endmodule

/* rtl/sifhSequencer.sv */
`timescale 1ns/1ps

module sifhSequencer #(
    parameter int NB = $bits(sifhTypesPkg::binAddr),
    parameter int CW = $bits(sifhTypesPkg::binCount)
) (
    input  logic                 clk,
    input  logic                 res,
    output logic                 dataWanted,   // to the TDC source
    output logic                 buildGo,
    output sifhCtrlPkg::passKind pass,
    output logic [NB-1:0]        window,
    input  logic                 buildDone,
    output logic                 scanGo,
    input  logic                 scanDone,
    input  logic [NB-1:0]        maxBin,
    input  logic [CW-1:0]        maxCount,
    input  logic                 builderWe,
    input  logic [NB-1:0]        builderWaddr,
    input  logic [CW-1:0]        builderWdata,
    output logic                 ramWe,
    output logic [NB-1:0]        ramWaddr,
    output logic [CW-1:0]        ramWdata,
    output logic                 ramSel,       // 1 -> peak finder owns the read port
    output logic                 resReq,
    input  logic                 resAck,
    output logic [2*NB-1:0]      peak,
    output logic [CW-1:0]        peakCount
);

    import sifhCtrlPkg::*;

    seqState       state;
    seqState       nextState;
    logic [NB-1:0] clrAddr;     // clear write pointer
    logic          outOfReset;  // keeps the RAM untouched while res is low
    logic          clearing;
    logic          clrLast;
    logic          fineFound;

    assign clearing  = outOfReset && (state == CLEAR || state == FINE_CLEAR);
    assign clrLast   = clearing && (clrAddr == '1);
    assign fineFound = (state == FINE_PEAK) && scanDone;

    always_comb begin
        nextState = state;
        case (state)
            CLEAR:       if (clrLast) nextState = COARSE;
            COARSE:      if (buildDone) nextState = COARSE_PEAK;
            COARSE_PEAK: if (scanDone) nextState = WINDOW;
            WINDOW:      nextState = FINE_CLEAR;  // single cycle
            FINE_CLEAR:  if (clrLast) nextState = FINE;
            FINE:        if (buildDone) nextState = FINE_PEAK;
            FINE_PEAK:   if (scanDone) nextState = RESULT;
            // leave once both req and ack are back low
            RESULT:      if (!resReq && !resAck) nextState = CLEAR;
            default:     nextState = CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= CLEAR;
            clrAddr    <= '0;
            window     <= '0;
            resReq     <= 1'b0;
            outOfReset <= 1'b0;
        end else begin
            state      <= nextState;
            outOfReset <= 1'b1;
            if (clearing) clrAddr <= clrAddr + 1'b1;  // wraps to 0 after last bin
            if (state == WINDOW) window <= maxBin;    // coarse peak as filter
            if (fineFound) begin
                resReq <= 1'b1;
            end else if (state == RESULT && resAck) begin
                resReq <= 1'b0;
            end
        end
    end

    // result payload, held for the whole handshake
    always_ff @(posedge clk) begin
        if (fineFound) begin
            peak      <= {window, maxBin};
            peakCount <= maxCount;
        end
    end

    assign dataWanted = (state == COARSE) || (state == FINE);
    assign buildGo    = (state == COARSE) || (state == FINE);
    assign pass       = (state == FINE) ? FINE_PASS : COARSE_PASS;
    assign scanGo     = (state == COARSE_PEAK) || (state == FINE_PEAK);
    assign ramSel     = scanGo;

    // write port mux, clear counter or builder
    assign ramWe    = clearing ? 1'b1 : builderWe;
    assign ramWaddr = clearing ? clrAddr : builderWaddr;
    assign ramWdata = clearing ? '0 : builderWdata;

endmodule

/* rtl/peakFinder.sv */
`timescale 1ns/1ps

module peakFinder #(
    parameter int NB = $bits(sifhTypesPkg::binAddr),
    parameter int CW = $bits(sifhTypesPkg::binCount)
) (
    input  logic          clk,
    input  logic          res,
    input  logic          scanGo,     // level, held until scanDone
    output logic [NB-1:0] ramRaddr,
    input  logic [CW-1:0] ramRdata,
    output logic [NB-1:0] maxBin,     // first bin with the highest count
    output logic [CW-1:0] maxCount,
    output logic          scanDone    // one cycle pulse, results valid
);

    logic [NB-1:0] rdAddr;    // address on the read port
    logic [NB-1:0] cmpAddr;   // address of the data now on ramRdata
    logic          rdValid;
    logic          cmpValid;
    logic          finished;  // blocks a rescan while scanGo stays high
    logic          start;

    assign start    = scanGo && !finished && !rdValid && !cmpValid;
    assign ramRaddr = rdAddr;

    // scan control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdValid  <= 1'b0;
            cmpValid <= 1'b0;
            finished <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            scanDone <= 1'b0;
            cmpValid <= rdValid;  // read latency of one cycle
            if (!scanGo) finished <= 1'b0;
            if (start) begin
                rdValid <= 1'b1;
            end else if (rdValid && rdAddr == '1) begin
                rdValid <= 1'b0;  // last bin issued
            end
            // last compare in flight
            if (cmpValid && !rdValid) begin
                scanDone <= 1'b1;
                finished <= 1'b1;
            end
        end
    end

    // address walk and running maximum
    always_ff @(posedge clk) begin
        if (start) begin
            rdAddr   <= '0;
            maxBin   <= '0;
            maxCount <= '0;
        end else if (rdValid) begin
            rdAddr <= rdAddr + 1'b1;
        end
        if (rdValid) cmpAddr <= rdAddr;
        // strictly greater so a tie keeps the lower bin
        if (cmpValid && ramRdata > maxCount) begin
            maxCount <= ramRdata;
            maxBin   <= cmpAddr;
        end
    end

endmodule

/* rtl/histogramBuilder.sv */
`timescale 1ns/1ps

module histogramBuilder #(
    parameter int NP    = $bits(sifhTypesPkg::tdcCode),
    parameter int NB    = $bits(sifhTypesPkg::binAddr),
    parameter int CW    = $bits(sifhTypesPkg::binCount),
    parameter int SHOTS = 64
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 buildGo,    // level, held during a pass
    input  sifhCtrlPkg::passKind pass,
    input  logic [NB-1:0]        window,     // coarse bin for the fine pass
    input  logic                 tdcReq,
    input  logic [NP-1:0]        tdc,
    output logic                 tdcAck,
    output logic [NB-1:0]        ramRaddr,
    input  logic [CW-1:0]        ramRdata,
    output logic                 ramWe,
    output logic [NB-1:0]        ramWaddr,
    output logic [CW-1:0]        ramWdata,
    output logic                 buildDone   // one cycle after the last handshake
);

    import sifhCtrlPkg::*;

    localparam int SW = $clog2(SHOTS + 1);

    typedef enum logic [1:0] {
        B_IDLE,  // wait for tdcReq
        B_ADDR,  // bin address on the read port
        B_READ,  // count arrives, write back
        B_ACK    // ack high until tdcReq drops
    } buildState;

    buildState     state;
    logic [SW-1:0] shotCnt;    // handshakes done in this pass
    logic [NB-1:0] binReg;     // bin of the timestamp in flight
    logic          hitReg;     // timestamp inside the window
    logic [NB-1:0] coarseBits;
    logic [NB-1:0] fineBits;
    logic          accept;

    assign coarseBits = tdc[NP-1 -: NB];
    assign fineBits   = tdc[NP-NB-1 -: NB];

    // stop taking timestamps once the frame is complete
    assign accept = buildGo && tdcReq && (shotCnt != SW'(SHOTS));

    // handshake and shot counting
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= B_IDLE;
            tdcAck    <= 1'b0;
            shotCnt   <= '0;
            buildDone <= 1'b0;
        end else begin
            buildDone <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (accept) state <= B_ADDR;
                    if (!buildGo) shotCnt <= '0;  // pass over, rearm
                end
                B_ADDR: state <= B_READ;
                B_READ: begin
                    state  <= B_ACK;
                    tdcAck <= 1'b1;  // increment written on this edge
                end
                B_ACK: begin
                    if (!tdcReq) begin
                        state   <= B_IDLE;
                        tdcAck  <= 1'b0;
                        shotCnt <= shotCnt + 1'b1;
                        if (shotCnt == SW'(SHOTS - 1)) buildDone <= 1'b1;
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    // capture bin while idle, tdc is stable under tdcReq
    always_ff @(posedge clk) begin
        if (state == B_IDLE) begin
            if (pass == FINE_PASS) begin
                binReg <= fineBits;
                hitReg <= (coarseBits == window);  // outside window, ack only
            end else begin
                binReg <= coarseBits;
                hitReg <= 1'b1;
            end
        end
    end

    assign ramRaddr = binReg;
    assign ramWaddr = binReg;
    assign ramWe    = (state == B_READ) && hitReg;
    // saturate at all ones
    assign ramWdata = (&ramRdata) ? ramRdata : ramRdata + 1'b1;

endmodule

/* rtl/histRam.sv */
`timescale 1ns/1ps

module histRam #(
    parameter int NB = $bits(sifhTypesPkg::binAddr),
    parameter int CW = $bits(sifhTypesPkg::binCount)
) (
    input  logic          clk,
    input  logic          we,     // write strobe
    input  logic [NB-1:0] waddr,
    input  logic [CW-1:0] wdata,
    input  logic [NB-1:0] raddr,
    output logic [CW-1:0] rdata   // valid one cycle after raddr
);

    // one count per bin
    logic [CW-1:0] mem [2**NB];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read
    // same-address read during a write sees the old count
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* rtl/sifhCtrlPkg.sv */
package sifhCtrlPkg;

    // measurement sequence
    typedef enum logic [2:0] {
        CLEAR,        // zero every bin
        COARSE,       // first frame, top bits
        COARSE_PEAK,  // scan for the coarse maximum
        WINDOW,       // latch coarse bin as filter
        FINE_CLEAR,   // zero again for pass two
        FINE,         // second frame, windowed
        FINE_PEAK,    // scan for the fine maximum
        RESULT        // result handshake
    } seqState;

    // which timestamp slice addresses the bin
    typedef enum logic {
        COARSE_PASS,  // tdc[NP-1 -: NB]
        FINE_PASS     // tdc[NP-NB-1 -: NB]
    } passKind;

endpackage

/* rtl/sifhTypesPkg.sv */
package sifhTypesPkg;

    // default data widths of the peak finder
    // the top level picks them up as NP, NB and CW and passes them down

    // raw timestamp from the TDC
    typedef logic [11:0] tdcCode;

    // bin index and RAM address
    // coarse pass uses the top bits of tdcCode, fine pass the bits below
    typedef logic [4:0] binAddr;   // 32 bins per histogram

    // hit count of one bin
    typedef logic [7:0] binCount;  // holds at all ones

    // result code
    // coarse bin in the upper half, fine bin in the lower half
    typedef logic [2*$bits(binAddr)-1:0] peakCode;

endpackage
